// ==== Makefile ====
# Verilator build and run for the memory server testbench

SRCS := $(filter-out +%,$(shell cat build.f))

obj_dir/Vmem_server_tb: build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f \
	  --top-module mem_server_tb --Mdir obj_dir -o Vmem_server_tb

run: obj_dir/Vmem_server_tb
	./obj_dir/Vmem_server_tb | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// ==== build.f ====
verilog/mem_msg_pkg.sv
verilog/mem_msg_fifo.sv
verilog/mem_storage.sv
verilog/mem_server_ctrl.sv
verilog/mem_server.sv
tb/mem_server_tb.sv

// ==== tb/mem_server_tb.sv ====
// ------------------------------------------------------------
// Testbench for the memory server
// Directed and random requests, reference memory model and
// concurrent checks on every response transfer
// ------------------------------------------------------------

`timescale 1ns/100ps

module mem_server_tb;

  localparam int num_words  = 256;
  localparam int wait_limit = 300;

  logic               clk;
  logic               rst;
  logic               req_val;
  logic               req_rdy;
  mem_pkg::mem_req_t  req_msg;
  logic               resp_val;
  logic               resp_rdy;
  mem_pkg::mem_resp_t resp_msg;

  // Reference model; an existing key is a written word
  logic [31:0]        model_mem [logic [7:0]];

  // Expected responses, ring with 8-bit pointers
  mem_pkg::mem_resp_t exp_mem [256];
  logic [7:0]         exp_wr;
  logic [7:0]         exp_rd;
  mem_pkg::mem_resp_t exp_head;
  logic               exp_pending;

  // 0 ready, 1 random stalls, 2 blocked
  int                 rdy_mode;
  int                 check_errors;
  int                 timeout_errors;

  mem_server #(.num_words(num_words)) mem_server_i (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------

  // Word inside a 16-word window, random bits above the index alias
  function automatic logic [31:0] window_addr(input logic [3:0] word);
    logic [31:0] addr;
    addr      = $urandom;
    addr[9:2] = {4'h0, word};
    return addr;
  endfunction

  function automatic mem_pkg::mem_req_t make_req(input mem_pkg::mem_op_e op,
      input logic [31:0] addr, input logic [1:0] len, input logic [31:0] data,
      input logic [7:0] tag);
    mem_pkg::mem_req_t req;
    req.op     = op;
    req.opaque = tag;
    req.addr   = addr;
    req.len    = len;
    req.data   = data;
    return req;
  endfunction

  // Length rule: low len bytes, 0 means the full word
  function automatic mem_pkg::mem_resp_t model_apply(input mem_pkg::mem_req_t req);
    mem_pkg::mem_resp_t resp;
    logic [7:0]         idx;
    logic [31:0]        mask;
    logic [31:0]        word;
    idx         = req.addr[9:2];
    mask        = (req.len == 2'd0) ? 32'hffff_ffff : ((32'h1 << (8 * req.len)) - 32'h1);
    word        = model_mem.exists(idx) ? model_mem[idx] : 32'h0;
    resp.op     = req.op;
    resp.opaque = req.opaque;
    resp.addr   = req.addr;
    resp.len    = req.len;
    resp.data   = 32'h0;
    if (req.op == mem_pkg::mem_op_write) begin
      model_mem[idx] = (word & ~mask) | (req.data & mask);
    end else begin
      resp.data = word & mask;
    end
    return resp;
  endfunction

  // Hold the request until it transfers
  task automatic send_req(input mem_pkg::mem_req_t msg);
    int cycles;
    cycles = 0;
    req_val <= 1'b1;
    req_msg <= msg;
    @(posedge clk);
    while (!req_rdy && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!req_rdy) begin
      timeout_errors++;
      $display("Timeout at %0t: request tag %02h was never accepted", $time, msg.opaque);
    end
    req_val <= 1'b0;
  endtask

  task automatic send_random(input logic [7:0] tag);
    send_req(make_req(mem_pkg::mem_op_e'($urandom_range(1)), window_addr(4'($urandom)),
      2'($urandom), $urandom, tag));
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_pending && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_pending) begin
      timeout_errors++;
      $display("Timeout at %0t: accepted requests still lack a response", $time);
    end
  endtask

  // ------------------------------------------------------------
  // Reference model and expected-response ring
  // ------------------------------------------------------------

  always @(posedge clk) begin
    if (rst) begin
      model_mem.delete();
      exp_wr <= '0;
      exp_rd <= '0;
    end else begin
      if (req_val && req_rdy) begin
        exp_mem[exp_wr] <= model_apply(req_msg);
        exp_wr          <= exp_wr + 8'd1;
      end
      if (resp_val && resp_rdy) begin
        exp_rd <= exp_rd + 8'd1;
      end
    end
  end

  assign exp_head    = exp_mem[exp_rd];
  assign exp_pending = (exp_wr != exp_rd);

  // Response sink readiness
  always @(posedge clk) begin
    case (rdy_mode)
      0:       resp_rdy <= 1'b1;
      1:       resp_rdy <= ($urandom_range(3) != 0);
      default: resp_rdy <= 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> (!resp_val && req_rdy))
    else begin
      check_errors++;
      $display("[FAIL] %0t after reset resp_val=%0b req_rdy=%0b", $time, resp_val, req_rdy);
    end

  a_resp_expected: assert property (@(posedge clk) disable iff (rst)
    (resp_val && resp_rdy) |-> exp_pending)
    else begin
      check_errors++;
      $display("[FAIL] %0t response tag %02h with no request outstanding",
        $time, resp_msg.opaque);
    end

  // Order, echoed fields and data in one compare
  a_resp_match: assert property (@(posedge clk) disable iff (rst)
    (resp_val && resp_rdy && exp_pending) |-> (resp_msg == exp_head))
    else begin
      check_errors++;
      $display("[FAIL] %0t got op=%0d tag=%02h addr=%08h len=%0d data=%08h", $time,
        resp_msg.op, resp_msg.opaque, resp_msg.addr, resp_msg.len, resp_msg.data);
      $display("  expected op=%0d tag=%02h addr=%08h len=%0d data=%08h",
        exp_head.op, exp_head.opaque, exp_head.addr, exp_head.len, exp_head.data);
    end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------

  initial begin
    bit stalled;
    void'($urandom(32'h58b6_1419));
    rst            = 1'b1;
    req_val        = 1'b0;
    req_msg        = '0;
    resp_rdy       = 1'b0;
    rdy_mode       = 0;
    check_errors   = 0;
    timeout_errors = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Unwritten read, then full-word write and read back
    send_req(make_req(mem_pkg::mem_op_read, window_addr(4'd4), 2'd0, 32'h0, 8'h01));
    send_req(make_req(mem_pkg::mem_op_write, window_addr(4'd1), 2'd0, 32'hdead_beef, 8'h02));
    send_req(make_req(mem_pkg::mem_op_read, window_addr(4'd1), 2'd0, 32'h0, 8'h03));

    // Partial writes merge low bytes through aliased addresses
    send_req(make_req(mem_pkg::mem_op_write, window_addr(4'd2), 2'd0, 32'h1122_3344, 8'h04));
    send_req(make_req(mem_pkg::mem_op_write, window_addr(4'd2), 2'd1, 32'haabb_ccdd, 8'h05));
    send_req(make_req(mem_pkg::mem_op_read, window_addr(4'd2), 2'd2, 32'h0, 8'h06));
    send_req(make_req(mem_pkg::mem_op_write, window_addr(4'd3), 2'd3, 32'h5566_7788, 8'h07));
    send_req(make_req(mem_pkg::mem_op_read, window_addr(4'd3), 2'd0, 32'h0, 8'h08));
    wait_drain();

    // Random traffic under random stalls
    rdy_mode <= 1;
    for (int i = 0; i < 64; i++) begin
      send_random(8'(i + 16));
    end
    rdy_mode <= 0;
    wait_drain();

    // Blocked responses back up into the request queue
    rdy_mode <= 2;
    stalled  = 1'b0;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 24 && !stalled; i++) begin
      @(posedge clk);
      if (!req_rdy) begin
        stalled = 1'b1;
      end else begin
        send_random(8'(i + 128));
      end
    end
    a_stall_seen: assert (stalled)
      else begin
        check_errors++;
        $display("[FAIL] %0t req_rdy never dropped while responses were blocked", $time);
      end
    repeat (10) @(posedge clk);
    rdy_mode <= 0;
    wait_drain();

    // Second reset clears every written word
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int w = 0; w < 16; w++) begin
      send_req(make_req(mem_pkg::mem_op_read, window_addr(4'(w)), 2'd0, 32'h0, 8'(w + 192)));
    end
    wait_drain();

    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== verilog/mem_msg_fifo.sv ====
// ------------------------------------------------------------
// Message queue with valid/ready on enqueue and dequeue side
// Circular buffer of flat vectors, one entry per message
// ------------------------------------------------------------

`timescale 1ns/100ps

module mem_msg_fifo #(
  parameter int width = 75,
  parameter int depth = 4
) (
  input  logic             clk,
  input  logic             rst,

  input  logic             enq_val,
  output logic             enq_rdy,
  input  logic [width-1:0] enq_msg,

  output logic             deq_val,
  input  logic             deq_rdy,
  output logic [width-1:0] deq_msg
);

  localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_bits = $clog2(depth + 1);

  logic [width-1:0]    slots [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                enq_fire;
  logic                deq_fire;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_bits-1:0] ptr_inc(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Readiness from occupancy only
  assign enq_rdy  = (count != cnt_bits'(depth));
  assign deq_val  = (count != '0);
  assign deq_msg  = slots[rd_ptr];

  assign enq_fire = enq_val && enq_rdy;
  assign deq_fire = deq_val && deq_rdy;

  // ------------------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (deq_fire) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves count alone
      if (enq_fire && !deq_fire) begin
        count <= count + 1'b1;
      end else if (deq_fire && !enq_fire) begin
        count <= count - 1'b1;
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (enq_fire) begin
      slots[wr_ptr] <= enq_msg;
    end
  end

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------

  // Pointers meet only when the queue is empty or full
  a_ptr_count: assert property (@(posedge clk) disable iff (rst)
    (wr_ptr == rd_ptr) == ((count == '0) || (count == cnt_bits'(depth))))
    else $error("mem_msg_fifo: occupancy count disagrees with pointers");

  // Head must stay put while the consumer stalls
  a_head_stable: assert property (@(posedge clk) disable iff (rst)
    (deq_val && !deq_rdy) |=> (deq_val && $stable(deq_msg)))
    else $error("mem_msg_fifo: head changed before dequeue");

endmodule

// ==== verilog/mem_msg_pkg.sv ====
// ------------------------------------------------------------
// Memory message definitions shared by the server RTL
// Field widths, op and controller state enums, and the
// request and response structs
// ------------------------------------------------------------

package mem_pkg;

  // ------------------------------------------------------------
  // Field widths
  // ------------------------------------------------------------

  localparam int mem_addr_bits   = 32;
  localparam int mem_data_bits   = 32;
  localparam int mem_opaque_bits = 8;
  // Byte count, 0 encodes a full word
  localparam int mem_len_bits    = 2;

  // ------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------

  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_e;

  // Server controller FSM states
  typedef enum logic [1:0] {
    st_idle    = 2'd0,
    st_access  = 2'd1,
    st_respond = 2'd2
  } mem_ctrl_state_e;

  // ------------------------------------------------------------
  // Messages
  // ------------------------------------------------------------

  typedef struct packed {
    mem_op_e                    op;
    logic [mem_opaque_bits-1:0] opaque;
    logic [mem_addr_bits-1:0]   addr;
    logic [mem_len_bits-1:0]    len;
    logic [mem_data_bits-1:0]   data;
  } mem_req_t;

  // Same layout; data is read data, or zero for a write
  typedef struct packed {
    mem_op_e                    op;
    logic [mem_opaque_bits-1:0] opaque;
    logic [mem_addr_bits-1:0]   addr;
    logic [mem_len_bits-1:0]    len;
    logic [mem_data_bits-1:0]   data;
  } mem_resp_t;

endpackage

// ==== verilog/mem_server.sv ====
// ------------------------------------------------------------
// Memory server top level
// Request queue, controller, storage and response queue
// ------------------------------------------------------------

`timescale 1ns/100ps

module mem_server #(
  parameter int num_words = 256
) (
  input  logic               clk,
  input  logic               rst,

  input  logic               req_val,
  output logic               req_rdy,
  input  mem_pkg::mem_req_t  req_msg,

  output logic               resp_val,
  input  logic               resp_rdy,
  output mem_pkg::mem_resp_t resp_msg
);

  localparam int req_bits    = $bits(mem_pkg::mem_req_t);
  localparam int resp_bits   = $bits(mem_pkg::mem_resp_t);
  localparam int queue_depth = 4;

  // Queue to controller
  logic                              ctrl_req_val;
  logic                              ctrl_req_rdy;
  mem_pkg::mem_req_t                 ctrl_req_msg;

  // Controller to queue
  logic                              ctrl_resp_val;
  logic                              ctrl_resp_rdy;
  mem_pkg::mem_resp_t                ctrl_resp_msg;

  // Storage port
  logic [$clog2(num_words)-1:0]      word_idx;
  logic                              wr_en;
  logic [mem_pkg::mem_data_bits/8-1:0] byte_en;
  logic [mem_pkg::mem_data_bits-1:0] wr_data;
  logic [mem_pkg::mem_data_bits-1:0] rd_data;
  logic                              rd_written;

  mem_msg_fifo #(.width(req_bits), .depth(queue_depth)) req_queue (
    .clk     (clk),
    .rst     (rst),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .enq_msg (req_msg),
    .deq_val (ctrl_req_val),
    .deq_rdy (ctrl_req_rdy),
    .deq_msg (ctrl_req_msg)
  );

  mem_server_ctrl #(.num_words(num_words)) ctrl (
    .clk        (clk),
    .rst        (rst),
    .req_val    (ctrl_req_val),
    .req_rdy    (ctrl_req_rdy),
    .req_msg    (ctrl_req_msg),
    .resp_val   (ctrl_resp_val),
    .resp_rdy   (ctrl_resp_rdy),
    .resp_msg   (ctrl_resp_msg),
    .word_idx   (word_idx),
    .wr_en      (wr_en),
    .byte_en    (byte_en),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .rd_written (rd_written)
  );

  mem_storage #(.num_words(num_words)) storage (
    .clk        (clk),
    .rst        (rst),
    .word_idx   (word_idx),
    .wr_en      (wr_en),
    .byte_en    (byte_en),
    .wr_data    (wr_data),
    .rd_data    (rd_data),
    .rd_written (rd_written)
  );

  // Free-slot state on enq_rdy gates the controller's pop
  mem_msg_fifo #(.width(resp_bits), .depth(queue_depth)) resp_queue (
    .clk     (clk),
    .rst     (rst),
    .enq_val (ctrl_resp_val),
    .enq_rdy (ctrl_resp_rdy),
    .enq_msg (ctrl_resp_msg),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy),
    .deq_msg (resp_msg)
  );

endmodule

// ==== verilog/mem_server_ctrl.sv ====
// ------------------------------------------------------------
// Memory server controller FSM
// Pops one request, runs it against the storage, then pushes
// the matching response
// ------------------------------------------------------------

`timescale 1ns/100ps

module mem_server_ctrl #(
  parameter int num_words = 256
) (
  input  logic                                  clk,
  input  logic                                  rst,

  // Request queue dequeue side
  input  logic                                  req_val,
  output logic                                  req_rdy,
  input  mem_pkg::mem_req_t                     req_msg,

  // Response queue enqueue side
  output logic                                  resp_val,
  input  logic                                  resp_rdy,
  output mem_pkg::mem_resp_t                    resp_msg,

  // Storage access
  output logic [$clog2(num_words)-1:0]          word_idx,
  output logic                                  wr_en,
  output logic [mem_pkg::mem_data_bits/8-1:0]   byte_en,
  output logic [mem_pkg::mem_data_bits-1:0]     wr_data,
  input  logic [mem_pkg::mem_data_bits-1:0]     rd_data,
  input  logic                                  rd_written
);

  localparam int idx_bits  = $clog2(num_words);
  localparam int num_bytes = mem_pkg::mem_data_bits / 8;

  mem_pkg::mem_ctrl_state_e          state;
  mem_pkg::mem_ctrl_state_e          state_next;
  mem_pkg::mem_req_t                 cur_req;
  logic                              req_fire;
  logic [mem_pkg::mem_data_bits-1:0] data_mask;
  logic [mem_pkg::mem_data_bits-1:0] rd_masked;

  // Byte count to low-byte enables, 0 means all bytes
  function automatic logic [num_bytes-1:0] len_to_byte_en(
    input logic [mem_pkg::mem_len_bits-1:0] len
  );
    case (len)
      2'd1:    return 4'b0001;
      2'd2:    return 4'b0011;
      2'd3:    return 4'b0111;
      default: return 4'b1111;
    endcase
  endfunction

  // ------------------------------------------------------------
  // FSM
  // ------------------------------------------------------------

  // Only pop when the response is sure to have a slot
  assign req_rdy  = (state == mem_pkg::st_idle) && resp_rdy;
  assign req_fire = req_val && req_rdy;

  always_comb begin
    state_next = state;
    case (state)
      mem_pkg::st_idle: begin
        if (req_fire) begin
          state_next = mem_pkg::st_access;
        end
      end
      mem_pkg::st_access:  state_next = mem_pkg::st_respond;
      mem_pkg::st_respond: state_next = mem_pkg::st_idle;
      default:             state_next = mem_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mem_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  // Current request held for access and respond
  always_ff @(posedge clk) begin
    if (req_fire) begin
      cur_req <= req_msg;
    end
  end

  // ------------------------------------------------------------
  // Storage access
  // ------------------------------------------------------------

  // Byte address; low two bits select a byte, bits above the
  // word index alias
  assign word_idx = cur_req.addr[idx_bits+1:2];
  assign wr_en    = (state == mem_pkg::st_access) && (cur_req.op == mem_pkg::mem_op_write);
  assign byte_en  = len_to_byte_en(cur_req.len);
  assign wr_data  = cur_req.data;

  // ------------------------------------------------------------
  // Response
  // ------------------------------------------------------------

  always_comb begin
    for (int b = 0; b < num_bytes; b++) begin
      data_mask[b*8 +: 8] = {8{byte_en[b]}};
    end
  end

  // Unwritten word reads as zero
  assign rd_masked = rd_written ? (rd_data & data_mask) : '0;

  assign resp_val        = (state == mem_pkg::st_respond);
  assign resp_msg.op     = cur_req.op;
  assign resp_msg.opaque = cur_req.opaque;
  assign resp_msg.addr   = cur_req.addr;
  assign resp_msg.len    = cur_req.len;
  assign resp_msg.data   = (cur_req.op == mem_pkg::mem_op_read) ? rd_masked : '0;

  // ------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------

  // Space reserved in idle must still be there at push time
  a_push_has_space: assert property (@(posedge clk) disable iff (rst)
    resp_val |-> resp_rdy)
    else $error("mem_server_ctrl: response push without free slot");

endmodule

// ==== verilog/mem_storage.sv ====
// ------------------------------------------------------------
// Word storage array with byte write enables
// Synchronous read, per-word written flags cleared on reset
// ------------------------------------------------------------

`timescale 1ns/100ps

module mem_storage #(
  parameter int num_words = 256
) (
  input  logic                                  clk,
  input  logic                                  rst,

  input  logic [$clog2(num_words)-1:0]          word_idx,
  input  logic                                  wr_en,
  input  logic [mem_pkg::mem_data_bits/8-1:0]   byte_en,
  input  logic [mem_pkg::mem_data_bits-1:0]     wr_data,

  output logic [mem_pkg::mem_data_bits-1:0]     rd_data,
  output logic                                  rd_written
);

  localparam int num_bytes = mem_pkg::mem_data_bits / 8;

  logic [mem_pkg::mem_data_bits-1:0] words [num_words];
  logic [num_words-1:0]              written;

  // ------------------------------------------------------------
  // Written flags
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      written <= '0;
    end else if (wr_en) begin
      written[word_idx] <= 1'b1;
    end
  end

  // ------------------------------------------------------------
  // Data array
  // ------------------------------------------------------------

  // First write to a word zeroes the bytes it does not cover,
  // so stale contents from before reset never show through
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < num_bytes; b++) begin
        if (byte_en[b]) begin
          words[word_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
        end else if (!written[word_idx]) begin
          words[word_idx][b*8 +: 8] <= 8'h00;
        end
      end
    end
  end

  // Read port, one cycle latency
  always_ff @(posedge clk) begin
    rd_data    <= words[word_idx];
    rd_written <= written[word_idx];
  end

endmodule
